// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_v33_exec_core \
    -f sources.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    exit 1
fi
exit 0

// File: source/alu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module alu_execute (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ex_valid,
    input  v33_pkg::instr_class_e      cls,
    input  v33_pkg::alu_op_e           alu_op,
    input  logic                       wide,
    input  logic [2:0]                 dst,
    input  logic [1:0]                 flag_op,
    input  logic [v33_pkg::WORD_W-1:0] opa,
    input  logic [v33_pkg::WORD_W-1:0] opb,
    input  logic [v33_pkg::WORD_W-1:0] port,
    output logic                       wb_en,
    output logic                       wb_wide,
    output logic [2:0]                 wb_dst,
    output logic [v33_pkg::WORD_W-1:0] wb_data,
    output logic                       io_write,
    output logic [v33_pkg::WORD_W-1:0] io_addr,
    output logic [v33_pkg::WORD_W-1:0] io_data
);
    import v33_pkg::*;

    flags_t flg;
    flags_t alu_flg;
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    logic [WORD_W-1:0] res;
    logic [WORD_W-1:0] wb_next;
    logic [WORD_W:0] sum;
    logic [BYTE_W-1:0] psw_low;
    logic cin;
    logic is_sub;
    logic arith;
    logic carry;
    logic writes;

    assign a = wide ? opa : {{(WORD_W - BYTE_W){1'b0}}, opa[BYTE_W-1:0]};
    assign b = wide ? opb : {{(WORD_W - BYTE_W){1'b0}}, opb[BYTE_W-1:0]};
    assign is_sub = alu_op == ALU_SUB || alu_op == ALU_SBB || alu_op == ALU_CMP;
    assign cin = (alu_op == ALU_ADC || alu_op == ALU_SBB) && flg.cy;
    assign arith = !(alu_op == ALU_OR || alu_op == ALU_AND || alu_op == ALU_XOR);

    always_comb begin
        if (is_sub) begin
            sum = {1'b0, a} - {1'b0, b} - (WORD_W + 1)'(cin); // Top bit is the borrow
        end else begin
            sum = {1'b0, a} + {1'b0, b} + (WORD_W + 1)'(cin);
        end
        case (alu_op)
            ALU_OR: res = a | b;
            ALU_AND: res = a & b;
            ALU_XOR: res = a ^ b;
            default: res = sum[WORD_W-1:0];
        endcase
        if (!wide) begin
            res[WORD_W-1:BYTE_W] = '0;
        end
        carry = wide ? sum[WORD_W] : sum[BYTE_W];
        alu_flg.cy = arith && carry;
        alu_flg.ac = arith && (a[4] ^ b[4] ^ sum[4]); // Out of bit 3
        alu_flg.z = res == '0;
        alu_flg.s = wide ? res[WORD_W-1] : res[BYTE_W-1];
        alu_flg.p = ~^res[BYTE_W-1:0];
    end

    assign psw_low = PSW_LOW_FIXED
        | {flg.s, flg.z, 1'b0, flg.ac, 1'b0, flg.p, 1'b0, flg.cy};

    always_comb begin
        case (cls)
            CLS_MOV_IMM: wb_next = opb;
            CLS_CVT: begin
                if (flag_op[0]) begin
                    wb_next = {WORD_W{opa[WORD_W-1]}};
                end else begin
                    wb_next = {{BYTE_W{opa[BYTE_W-1]}}, opa[BYTE_W-1:0]};
                end
            end
            CLS_PSW_AH: wb_next = {psw_low, opa[BYTE_W-1:0]};
            default: wb_next = res;
        endcase
    end

    assign writes = cls == CLS_MOV_IMM || cls == CLS_CVT || cls == CLS_PSW_AH
        || (cls == CLS_ALU && alu_op != ALU_CMP);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en <= 1'b0;
            io_write <= 1'b0;
            flg <= '0;
        end else begin
            wb_en <= ex_valid && writes;
            io_write <= ex_valid && cls == CLS_OUT;
            if (ex_valid && cls == CLS_ALU) begin
                flg <= alu_flg;
            end else if (ex_valid && cls == CLS_FLAG) begin
                flg.cy <= flag_op[1] ? flag_op[0] : !flg.cy; // SET1, CLR1 or NOT1
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_wide <= wide;
        wb_dst <= dst;
        wb_data <= wb_next;
        io_addr <= port;
        io_data <= a; // Byte OUT gives AL zero-extended
    end

endmodule

`default_nettype wire

// File: source/instruction_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [v33_pkg::BYTE_W-1:0]   q0,
    input  logic [v33_pkg::BYTE_W-1:0]   q1,
    input  logic [v33_pkg::BYTE_W-1:0]   q2,
    input  logic [$clog2(QUEUE_DEPTH):0] q_len,
    output logic                         pop,
    output logic [1:0]                   pop_count,
    input  logic                         hold,
    output logic                         dec_valid,
    output v33_pkg::instr_class_e        cls,
    output v33_pkg::alu_op_e             alu_op,
    output logic                         wide,
    output logic [2:0]                   dst,
    output logic [2:0]                   src,
    output logic                         src_is_imm,
    output logic [v33_pkg::WORD_W-1:0]   imm,
    output logic [1:0]                   flag_op
);
    import v33_pkg::*;

    localparam int LEN_W = $clog2(QUEUE_DEPTH) + 1;

    instr_class_e n_cls;
    logic [1:0] n_len;
    logic n_wide;
    logic [2:0] n_dst;
    logic [2:0] n_src;
    logic n_imm_src;
    logic ready;

    // Length depends on q0 alone, so a short queue never misleads it
    always_comb begin
        n_cls = CLS_NOP;
        n_len = 2'd1;
        n_wide = q0[0];
        n_dst = q1[2:0];
        n_src = q1[5:3];
        n_imm_src = 1'b0;
        casez (q0)
            8'b00???0??: begin
                n_len = 2'd2;
                if (q1[7:6] == 2'b11) begin
                    n_cls = CLS_ALU; // Memory forms fall through as NOP
                end
                if (q0[1]) begin // d bit, reg field is the destination
                    n_dst = q1[5:3];
                    n_src = q1[2:0];
                end
            end
            8'b00???10?: begin
                n_cls = CLS_ALU;
                n_len = q0[0] ? 2'd3 : 2'd2;
                n_dst = 3'(AW); // AL in the byte form
                n_imm_src = 1'b1;
            end
            8'b1011????: begin
                n_cls = CLS_MOV_IMM;
                n_wide = q0[3];
                n_len = q0[3] ? 2'd3 : 2'd2;
                n_dst = q0[2:0];
                n_imm_src = 1'b1;
            end
            8'hf5, 8'hf8, 8'hf9: begin
                n_cls = CLS_FLAG;
            end
            8'h98, 8'h99: begin
                n_cls = CLS_CVT;
                n_wide = 1'b1;
                n_dst = q0[0] ? DW : AW; // CVTWL fills DW, CVTBW rewrites AW
            end
            8'h9f: begin
                n_cls = CLS_PSW_AH;
                n_wide = 1'b1;
                n_dst = AW;
            end
            8'he6, 8'he7: begin
                n_cls = CLS_OUT;
                n_len = 2'd2;
                n_imm_src = 1'b1;
            end
            8'hee, 8'hef: begin
                n_cls = CLS_OUT;
                n_src = DW;
            end
            default: begin
                n_cls = CLS_NOP;
            end
        endcase
    end

    assign ready = q_len >= LEN_W'(n_len);
    assign pop = ready && !hold;
    assign pop_count = n_len;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (!hold) begin
            dec_valid <= ready;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cls <= n_cls;
            alu_op <= alu_op_e'(q0[5:3]);
            wide <= n_wide;
            dst <= n_dst;
            src <= n_src;
            src_is_imm <= n_imm_src;
            imm <= (n_len == 2'd3) ? {q2, q1} : {{(WORD_W - BYTE_W){1'b0}}, q1};
            // Bits 3 and 0 tell F5/F8/F9 and 98/99 apart
            flag_op <= {q0[3], q0[0]};
        end
    end

endmodule

`default_nettype wire

// File: source/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       dec_valid,
    input  v33_pkg::instr_class_e      cls,
    input  v33_pkg::alu_op_e           alu_op,
    input  logic                       wide,
    input  logic [2:0]                 dst,
    input  logic [2:0]                 src,
    input  logic                       src_is_imm,
    input  logic [v33_pkg::WORD_W-1:0] imm,
    input  logic [1:0]                 flag_op,
    output logic                       hold,
    output logic                       ex_valid,
    output v33_pkg::instr_class_e      ex_cls,
    output v33_pkg::alu_op_e           ex_alu_op,
    output logic                       ex_wide,
    output logic [2:0]                 ex_dst,
    output logic [1:0]                 ex_flag_op,
    output logic [v33_pkg::WORD_W-1:0] opa,
    output logic [v33_pkg::WORD_W-1:0] opb,
    output logic [v33_pkg::WORD_W-1:0] port,
    input  logic                       wb_en,
    input  logic                       wb_wide,
    input  logic [2:0]                 wb_dst,
    input  logic [v33_pkg::WORD_W-1:0] wb_data
);
    import v33_pkg::*;

    logic [WORD_W-1:0] regs [8];
    logic [2:0] rd_a;
    logic [2:0] rd_b;
    logic [2:0] ex_word;
    logic [2:0] wb_word;
    logic rd_a_en;
    logic rd_b_en;
    logic ex_writes;
    logic hit_ex;
    logic hit_wb;

    // Word register holding a byte or word index
    function automatic logic [2:0] word_of(input logic [2:0] idx, input logic w);
        return w ? idx : {1'b0, idx[1:0]};
    endfunction

    function automatic logic [WORD_W-1:0] read_op(input logic [2:0] idx, input logic w);
        logic [WORD_W-1:0] r;
        r = regs[word_of(idx, w)];
        if (w) begin
            return r;
        end
        return {{(WORD_W - BYTE_W){1'b0}}, idx[2] ? r[WORD_W-1:BYTE_W] : r[BYTE_W-1:0]};
    endfunction

    // Registers the decoded instruction reads
    assign rd_a = (cls == CLS_ALU) ? word_of(dst, wide) : 3'(AW);
    assign rd_a_en = cls == CLS_ALU || cls == CLS_CVT || cls == CLS_PSW_AH || cls == CLS_OUT;
    assign rd_b = word_of(src, wide);
    assign rd_b_en = !src_is_imm && (cls == CLS_ALU || cls == CLS_OUT);

    assign ex_word = word_of(ex_dst, ex_wide);
    assign wb_word = word_of(wb_dst, wb_wide);
    assign ex_writes = ex_valid && (ex_cls == CLS_MOV_IMM || ex_cls == CLS_CVT
        || ex_cls == CLS_PSW_AH || (ex_cls == CLS_ALU && ex_alu_op != ALU_CMP));

    assign hit_ex = ex_writes && ((rd_a_en && rd_a == ex_word) || (rd_b_en && rd_b == ex_word));
    assign hit_wb = wb_en && ((rd_a_en && rd_a == wb_word) || (rd_b_en && rd_b == wb_word));

    // Back-to-back OUTs get a bubble so each strobe stands alone
    assign hold = dec_valid
        && (hit_ex || hit_wb || (cls == CLS_OUT && ex_valid && ex_cls == CLS_OUT));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            if (wb_wide) begin
                regs[wb_dst] <= wb_data;
            end else if (wb_dst[2]) begin
                regs[wb_word][WORD_W-1:BYTE_W] <= wb_data[BYTE_W-1:0];
            end else begin
                regs[wb_word][BYTE_W-1:0] <= wb_data[BYTE_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid && !hold; // Bubble while stalled
        end
    end

    always_ff @(posedge clk) begin
        ex_cls <= cls;
        ex_alu_op <= alu_op;
        ex_wide <= wide;
        ex_dst <= dst;
        ex_flag_op <= flag_op;
        opa <= (cls == CLS_ALU) ? read_op(dst, wide) : regs[AW]; // AW for CVT, PSW and OUT
        opb <= src_is_imm ? imm : read_op(src, wide);
        port <= src_is_imm ? imm : regs[DW];
    end

endmodule

`default_nettype wire

// File: source/prefetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [v33_pkg::BYTE_W-1:0]   code_byte,
    input  logic                         code_valid,
    output logic                         code_req,
    output logic [v33_pkg::BYTE_W-1:0]   q0,
    output logic [v33_pkg::BYTE_W-1:0]   q1,
    output logic [v33_pkg::BYTE_W-1:0]   q2,
    output logic [$clog2(QUEUE_DEPTH):0] q_len,
    input  logic                         pop,
    input  logic [1:0]                   pop_count
);
    import v33_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] FULL = (PTR_W + 1)'(QUEUE_DEPTH);

    logic [BYTE_W-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0] count;
    logic [PTR_W:0] pop_n;
    logic push;

    assign code_req = count < FULL;
    assign push = code_valid && code_req;
    assign pop_n = pop ? (PTR_W + 1)'(pop_count) : '0;

    // Pointers wrap on their own since the depth is a power of two
    assign q0 = mem[head];
    assign q1 = mem[head + PTR_W'(1)];
    assign q2 = mem[head + PTR_W'(2)];
    assign q_len = count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= code_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + PTR_W'(1);
            end
            if (pop) begin
                head <= head + PTR_W'(pop_count);
            end
            count <= count + (PTR_W + 1)'(push) - pop_n; // Push and pop may overlap
        end
    end

endmodule

`default_nettype wire

// File: source/v33_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module v33_exec_core #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [v33_pkg::BYTE_W-1:0] code_byte,
    input  logic                       code_valid,
    output logic                       code_req,
    output logic                       io_write,
    output logic [v33_pkg::WORD_W-1:0] io_addr,
    output logic [v33_pkg::WORD_W-1:0] io_data
);
    import v33_pkg::*;

    logic [BYTE_W-1:0] q0;
    logic [BYTE_W-1:0] q1;
    logic [BYTE_W-1:0] q2;
    logic [$clog2(QUEUE_DEPTH):0] q_len;
    logic pop;
    logic [1:0] pop_count;

    logic hold;
    logic dec_valid;
    instr_class_e dec_cls;
    alu_op_e dec_alu_op;
    logic dec_wide;
    logic [2:0] dec_dst;
    logic [2:0] dec_src;
    logic dec_src_is_imm;
    logic [WORD_W-1:0] dec_imm;
    logic [1:0] dec_flag_op;

    logic ex_valid;
    instr_class_e ex_cls;
    alu_op_e ex_alu_op;
    logic ex_wide;
    logic [2:0] ex_dst;
    logic [1:0] ex_flag_op;
    logic [WORD_W-1:0] opa;
    logic [WORD_W-1:0] opb;
    logic [WORD_W-1:0] port;

    logic wb_en;
    logic wb_wide;
    logic [2:0] wb_dst;
    logic [WORD_W-1:0] wb_data;

    prefetch_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .reset      (reset),
        .code_byte  (code_byte),
        .code_valid (code_valid),
        .code_req   (code_req),
        .q0         (q0),
        .q1         (q1),
        .q2         (q2),
        .q_len      (q_len),
        .pop        (pop),
        .pop_count  (pop_count)
    );

    instruction_decoder #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_decoder (
        .clk        (clk),
        .reset      (reset),
        .q0         (q0),
        .q1         (q1),
        .q2         (q2),
        .q_len      (q_len),
        .pop        (pop),
        .pop_count  (pop_count),
        .hold       (hold),
        .dec_valid  (dec_valid),
        .cls        (dec_cls),
        .alu_op     (dec_alu_op),
        .wide       (dec_wide),
        .dst        (dec_dst),
        .src        (dec_src),
        .src_is_imm (dec_src_is_imm),
        .imm        (dec_imm),
        .flag_op    (dec_flag_op)
    );

    operand_stage u_operand (
        .clk        (clk),
        .reset      (reset),
        .dec_valid  (dec_valid),
        .cls        (dec_cls),
        .alu_op     (dec_alu_op),
        .wide       (dec_wide),
        .dst        (dec_dst),
        .src        (dec_src),
        .src_is_imm (dec_src_is_imm),
        .imm        (dec_imm),
        .flag_op    (dec_flag_op),
        .hold       (hold),
        .ex_valid   (ex_valid),
        .ex_cls     (ex_cls),
        .ex_alu_op  (ex_alu_op),
        .ex_wide    (ex_wide),
        .ex_dst     (ex_dst),
        .ex_flag_op (ex_flag_op),
        .opa        (opa),
        .opb        (opb),
        .port       (port),
        .wb_en      (wb_en),
        .wb_wide    (wb_wide),
        .wb_dst     (wb_dst),
        .wb_data    (wb_data)
    );

    alu_execute u_execute (
        .clk      (clk),
        .reset    (reset),
        .ex_valid (ex_valid),
        .cls      (ex_cls),
        .alu_op   (ex_alu_op),
        .wide     (ex_wide),
        .dst      (ex_dst),
        .flag_op  (ex_flag_op),
        .opa      (opa),
        .opb      (opb),
        .port     (port),
        .wb_en    (wb_en),
        .wb_wide  (wb_wide),
        .wb_dst   (wb_dst),
        .wb_data  (wb_data),
        .io_write (io_write),
        .io_addr  (io_addr),
        .io_data  (io_data)
    );

endmodule

`default_nettype wire

// File: source/v33_pkg.sv
`default_nettype none

package v33_pkg;

    localparam int WORD_W = 16;
    localparam int BYTE_W = 8;

    // Only the flags this core still keeps
    typedef struct packed {
        logic s;
        logic z;
        logic ac;
        logic p;
        logic cy;
    } flags_t;

    // Low PSW byte is S Z 0 AC 0 P 1 CY, bit 1 always reads one
    localparam logic [BYTE_W-1:0] PSW_LOW_FIXED = 8'b0000_0010;

    typedef enum logic [2:0] {
        AW,
        CW,
        DW,
        BW,
        SP,
        BP,
        IX,
        IY
    } reg16_index_e;

    // Bit 2 picks the high half of AW..BW
    typedef enum logic [2:0] {
        AL,
        CL,
        DL,
        BL,
        AH,
        CH,
        DH,
        BH
    } reg8_index_e;

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_OR,
        ALU_ADC,
        ALU_SBB,
        ALU_AND,
        ALU_SUB,
        ALU_XOR,
        ALU_CMP
    } alu_op_e;

    typedef enum logic [2:0] {
        CLS_NOP,
        CLS_MOV_IMM,
        CLS_ALU,
        CLS_FLAG,
        CLS_CVT,
        CLS_PSW_AH,
        CLS_OUT
    } instr_class_e;

endpackage

`default_nettype wire

// File: sources.f
source/v33_pkg.sv
source/prefetch_queue.sv
source/instruction_decoder.sv
source/operand_stage.sv
source/alu_execute.sv
source/v33_exec_core.sv
testbench/v33_exec_core_sva.sv
testbench/tb_v33_exec_core.sv

// File: testbench/tb_v33_exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_v33_exec_core;

    logic clk;
    logic reset;
    logic [7:0] code_byte;
    logic code_valid;
    logic code_req;
    logic io_write;
    logic [15:0] io_addr;
    logic [15:0] io_data;

    integer seed = 32'h842219e6;
    logic [7:0] prog [$];
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    logic [15:0] m_regs [8];
    logic m_cy;
    logic m_p;
    logic m_ac;
    logic m_z;
    logic m_s;
    logic [15:0] ea;
    logic [15:0] ed;
    int sent = 0;
    int full_waits = 0;
    int checks = 0;
    int mismatches = 0;
    int other_errs = 0;
    logic gen_done = 1'b0;

    v33_exec_core #(.QUEUE_DEPTH(8)) uut (
        .clk(clk), .reset(reset), .code_byte(code_byte), .code_valid(code_valid),
        .code_req(code_req), .io_write(io_write), .io_addr(io_addr), .io_data(io_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] get_reg(input logic [2:0] idx, input logic w);
        if (w) return m_regs[idx];
        return idx[2] ? {8'h00, m_regs[idx[1:0]][15:8]} : {8'h00, m_regs[idx[1:0]][7:0]};
    endfunction

    function void set_reg(input logic [2:0] idx, input logic w, input logic [15:0] v);
        if (w) m_regs[idx] = v;
        else if (idx[2]) m_regs[idx[1:0]][15:8] = v[7:0];
        else m_regs[idx[1:0]][7:0] = v[7:0];
    endfunction

    // Two-operand ALU with the flag rules, borrow for the subtract group
    function logic [15:0] alu_ref(input logic [2:0] op, input logic w,
                                  input logic [15:0] a, input logic [15:0] b);
        int full;
        int cin;
        logic [15:0] mask;
        logic [15:0] res;
        mask = w ? 16'hffff : 16'h00ff;
        cin = (op == 3'd2 || op == 3'd3) ? int'(m_cy) : 0;
        case (op)
            3'd0, 3'd2: begin
                full = int'(a) + int'(b) + cin;
                m_cy = full > int'(mask);
                m_ac = (int'(a & 16'hf) + int'(b & 16'hf) + cin) > 15;
            end
            3'd3, 3'd5, 3'd7: begin
                full = int'(a) - int'(b) - cin;
                m_cy = int'(a) < int'(b) + cin;
                m_ac = int'(a & 16'hf) < int'(b & 16'hf) + cin;
            end
            default: begin
                full = (op == 3'd1) ? int'(a | b) : (op == 3'd4) ? int'(a & b) : int'(a ^ b);
                m_cy = 1'b0;
                m_ac = 1'b0;
            end
        endcase
        res = full[15:0] & mask;
        m_z = res == 16'h0;
        m_s = w ? res[15] : res[7];
        m_p = ~^res[7:0];
        return res;
    endfunction

    // Steps the model by one instruction, queues the expected OUT pairs
    function void model_step(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
        logic [2:0] d_idx;
        logic [2:0] s_idx;
        logic [15:0] r;
        if (b0[7:6] == 2'b00 && b0[2] == 1'b0) begin
            d_idx = b0[1] ? b1[5:3] : b1[2:0];
            s_idx = b0[1] ? b1[2:0] : b1[5:3];
            r = alu_ref(b0[5:3], b0[0], get_reg(d_idx, b0[0]), get_reg(s_idx, b0[0]));
            if (b0[5:3] != 3'd7) set_reg(d_idx, b0[0], r);
        end else if (b0[7:6] == 2'b00 && b0[2:1] == 2'b10) begin
            r = alu_ref(b0[5:3], b0[0], get_reg(3'd0, b0[0]), b0[0] ? {b2, b1} : {8'h00, b1});
            if (b0[5:3] != 3'd7) set_reg(3'd0, b0[0], r);
        end else if (b0[7:4] == 4'hb) begin
            set_reg(b0[2:0], b0[3], b0[3] ? {b2, b1} : {8'h00, b1});
        end else begin
            case (b0)
                8'hf5: m_cy = !m_cy;
                8'hf8: m_cy = 1'b0;
                8'hf9: m_cy = 1'b1;
                8'h98: m_regs[0] = {{8{m_regs[0][7]}}, m_regs[0][7:0]};
                8'h99: m_regs[2] = {16{m_regs[0][15]}};
                8'h9f: m_regs[0][15:8] = {m_s, m_z, 1'b0, m_ac, 1'b0, m_p, 1'b1, m_cy};
                8'he6, 8'he7, 8'hee, 8'hef: begin
                    exp_addr.push_back(b0[3] ? m_regs[2] : {8'h00, b1});
                    exp_data.push_back(b0[0] ? m_regs[0] : {8'h00, m_regs[0][7:0]});
                end
                default: ;
            endcase
        end
    endfunction

    task add_instr(input int len, input logic [7:0] b0, input logic [7:0] b1,
                   input logic [7:0] b2);
        prog.push_back(b0);
        if (len > 1) prog.push_back(b1);
        if (len > 2) prog.push_back(b2);
        model_step(b0, b1, b2);
    endtask

    task add_random_instr;
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = $random(seed);
        r2 = $random(seed);
        case (r1[31:16] % 10)
            0: begin
                if (r1[0]) add_instr(3, {5'b10111, r1[3:1]}, r2[7:0], r2[15:8]);
                else add_instr(2, {5'b10110, r1[3:1]}, r2[7:0], 8'h00);
            end
            1, 2: add_instr(2, {2'b00, r1[5:3], 1'b0, r1[1:0]}, {2'b11, r2[5:0]}, 8'h00);
            3: begin
                if (r1[0]) add_instr(3, {2'b00, r1[5:3], 3'b101}, r2[7:0], r2[15:8]);
                else add_instr(2, {2'b00, r1[5:3], 3'b100}, r2[7:0], 8'h00);
            end
            4: add_instr(1, (r2 % 3 == 0) ? 8'hf5 : (r2 % 3 == 1) ? 8'hf8 : 8'hf9, 0, 0);
            5: add_instr(1, r1[0] ? 8'h99 : 8'h98, 8'h00, 8'h00);
            6: add_instr(1, 8'h9f, 8'h00, 8'h00);
            7: add_instr(2, r1[0] ? 8'he7 : 8'he6, r2[7:0], 8'h00);
            8: add_instr(1, r1[0] ? 8'hef : 8'hee, 8'h00, 8'h00);
            default: add_instr(1, r1[0] ? 8'h90 : 8'hd6, 8'h00, 8'h00);
        endcase
    endtask

    // Byte driver, idle gaps only in the first half so the queue fills later
    always @(posedge clk) begin
        if (reset) begin
            code_valid <= 1'b0;
        end else begin
            if (code_valid && code_req) sent = sent + 1;
            if (code_valid && !code_req) begin
                full_waits++; // Byte waits at the source
                code_valid <= 1'b1;
            end else if (sent < prog.size() && code_req
                         && !(sent < prog.size() / 2 && $random(seed) % 4 == 0)) begin
                code_valid <= 1'b1;
                code_byte <= prog[sent];
            end else begin
                code_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && io_write) begin
            if (exp_addr.size() == 0) begin
                other_errs++;
                $display("io_write strobe arrived with no OUT left in the model");
            end else begin
                ea = exp_addr.pop_front();
                ed = exp_data.pop_front();
                checks++;
                if (io_addr !== ea) begin
                    mismatches++;
                    $display("Mismatch io_addr: got %h expected %h", io_addr, ea);
                end
                if (io_data !== ed) begin
                    mismatches++;
                    $display("Mismatch io_data: got %h expected %h", io_data, ed);
                end
            end
        end
    end

    initial begin
        wait (gen_done);
        repeat (prog.size() * 8 + 200) @(posedge clk);
        other_errs++;
        $display("Timeout with %0d OUT strobes still missing", exp_addr.size());
        $display("OUT strobes checked %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errs);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        reset = 1'b1;
        code_valid = 1'b0;
        code_byte = 8'h00;
        for (int i = 0; i < 8; i++) m_regs[i] = 16'h0;
        {m_cy, m_p, m_ac, m_z, m_s} = 5'b0;
        // MOV then OUT to both port forms
        add_instr(3, 8'hb8, 8'h34, 8'h12);
        add_instr(3, 8'hba, 8'h80, 8'h00);
        add_instr(2, 8'he7, 8'h55, 8'h00);
        add_instr(1, 8'hef, 8'h00, 8'h00);
        // Byte write to AH, then word reads of AW
        add_instr(2, 8'hb4, 8'h7f, 8'h00);
        add_instr(3, 8'h05, 8'h01, 8'h00);
        add_instr(2, 8'h03, 8'hc0, 8'h00);
        add_instr(2, 8'he7, 8'h01, 8'h00);
        add_instr(1, 8'hf9, 8'h00, 8'h00);
        add_instr(3, 8'h15, 8'hff, 8'hff);
        add_instr(1, 8'hf8, 8'h00, 8'h00);
        add_instr(3, 8'h1d, 8'h01, 8'h00);
        add_instr(1, 8'hf5, 8'h00, 8'h00);
        add_instr(1, 8'h9f, 8'h00, 8'h00);
        add_instr(2, 8'he7, 8'h02, 8'h00);
        // Sign fill, negative then positive
        add_instr(2, 8'hb0, 8'h85, 8'h00);
        add_instr(1, 8'h98, 8'h00, 8'h00);
        add_instr(1, 8'h99, 8'h00, 8'h00);
        add_instr(2, 8'he7, 8'h03, 8'h00);
        add_instr(1, 8'hef, 8'h00, 8'h00);
        add_instr(3, 8'hb8, 8'h7f, 8'h80);
        add_instr(1, 8'h98, 8'h00, 8'h00);
        add_instr(1, 8'h99, 8'h00, 8'h00);
        add_instr(2, 8'he6, 8'h04, 8'h00);
        add_instr(1, 8'hef, 8'h00, 8'h00);
        for (int i = 0; i < 400; i++) add_random_instr();
        // Dependent one-byte chain, the core drains slower than the source fills
        for (int i = 0; i < 12; i++) begin
            add_instr(1, 8'h9f, 8'h00, 8'h00);
            add_instr(1, 8'h98, 8'h00, 8'h00);
        end
        add_instr(2, 8'he7, 8'h10, 8'h00);
        add_instr(1, 8'hef, 8'h00, 8'h00);
        gen_done = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        if (code_req !== 1'b1) begin
            other_errs++;
            $display("code_req is low right after reset");
        end
        while (sent < prog.size() || exp_addr.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (full_waits == 0) begin
            other_errs++;
            $display("code_req never fell, the queue never filled");
        end
        $display("OUT strobes checked %0d, mismatches %0d, other errors %0d",
                 checks, mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/v33_exec_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

module v33_exec_core_sva #(
    parameter int LEN_W = 4
) (
    input logic             clk,
    input logic             reset,
    input logic             code_valid,
    input logic             code_req,
    input logic [LEN_W-1:0] q_len,
    input logic             hold,
    input logic             io_write
);

    // Each OUT gives exactly one strobe
    io_strobe_single: assert property (@(posedge clk) disable iff (reset)
        io_write |=> !io_write)
        else $error("io_write held high for two cycles");

    // A full queue must not grow
    no_take_when_full: assert property (@(posedge clk) disable iff (reset)
        (code_valid && !code_req) |=> q_len <= $past(q_len))
        else $error("byte taken while code_req was low");

    hold_bounded: assert property (@(posedge clk) disable iff (reset)
        hold ##1 hold |=> !hold)
        else $error("hold stayed high for more than two cycles");

endmodule

bind v33_exec_core v33_exec_core_sva #(
    .LEN_W($clog2(QUEUE_DEPTH) + 1)
) sva_i (
    .clk        (clk),
    .reset      (reset),
    .code_valid (code_valid),
    .code_req   (code_req),
    .q_len      (q_len),
    .hold       (hold),
    .io_write   (io_write)
);

`default_nettype wire
